/* source/dzcpuPkg.sv */
`default_nettype none

package dzcpuPkg;

	//////////////////////////////////////////////////////////////////////
	// Micro-op fields
	//////////////////////////////////////////////////////////////////////

	// What the sequencer does after a micro-op
	typedef enum logic [2:0]
	{
		op,
		inc,
		eof,
		incEof,
		// Z set ends the flow with pc stepped, else falls to next uop
		incEofZ
	} uopNextT;

	// Datapath operation of a micro-op
	typedef enum logic [3:0]
	{
		nop, sma, srm, smw, dec16, inc16, jcb,
		bitOp, sx16r, addx16, spc, oneByte
	} uopActT;

	// Operand select, 8-bit registers first, then the pairs
	typedef enum logic [4:0]
	{
		a, c, h, l, spl, sph, pc, hl, ioC, x8, x16, nullSel
	} regSelT;

	// One microcode ROM word, 12 bits
	typedef struct packed
	{
		uopNextT next;
		uopActT  act;
		regSelT  sel;
	} uopT;

	//////////////////////////////////////////////////////////////////////
	// Opcodes and flows
	//////////////////////////////////////////////////////////////////////

	// Decoded opcodes, main page and CB page share this type
	typedef enum logic [7:0]
	{
		mopNop   = 8'h00,
		incC     = 8'h0C,
		ldCn     = 8'h0E,
		jrNz     = 8'h20,
		ldHlNn   = 8'h21,
		ldSpNn   = 8'h31,
		ldHlDecA = 8'h32,
		ldAn     = 8'h3E,
		ldHlA    = 8'h77,
		bit7H    = 8'h7C,
		xorA     = 8'hAF,
		cbPrefix = 8'hCB,
		ldIoCA   = 8'hE2
	} mopT;

	typedef logic [7:0] flowIdxT;

	// Flow start addresses in the microcode ROM
	localparam flowIdxT flowOneByte  = 8'd0;
	localparam flowIdxT flowLdSpNn   = 8'd1;
	localparam flowIdxT flowLdHlNn   = 8'd5;
	localparam flowIdxT flowLdHlDecA = 8'd9;
	localparam flowIdxT flowCb       = 8'd12;
	localparam flowIdxT flowBit7H    = 8'd15;
	localparam flowIdxT flowJrNz     = 8'd16;
	localparam flowIdxT flowLdCn     = 8'd23;
	localparam flowIdxT flowLdAn     = 8'd26;
	localparam flowIdxT flowLdIoCA   = 8'd29;
	localparam flowIdxT flowIncC     = 8'd32;
	localparam flowIdxT flowLdHlA    = 8'd33;

	// Fetch and decode phases of the sequencer
	typedef enum logic [1:0]
	{
		fetchAddr, fetchWait, decode, execute
	} fetchStateT;

endpackage

`default_nettype wire

/* source/dzcpuFlowLut.sv */
`timescale 1ns/1ps
`default_nettype none

module dzcpuFlowLut
(
	input  wire dzcpuPkg::mopT      mop,
	input  wire                     cbPage,
	output dzcpuPkg::flowIdxT       flowIdx
);

	// Opcode to flow start, two pages
	always_comb
	begin
		flowIdx = dzcpuPkg::flowOneByte;
		if (cbPage)
		begin
			// CB page, only BIT 7,H has a flow
			case (mop)
			dzcpuPkg::bit7H: flowIdx = dzcpuPkg::flowBit7H;
			default:         flowIdx = dzcpuPkg::flowOneByte;
			endcase
		end
		else
		begin
			case (mop)
			dzcpuPkg::ldSpNn:   flowIdx = dzcpuPkg::flowLdSpNn;
			dzcpuPkg::ldHlNn:   flowIdx = dzcpuPkg::flowLdHlNn;
			dzcpuPkg::ldHlDecA: flowIdx = dzcpuPkg::flowLdHlDecA;
			dzcpuPkg::cbPrefix: flowIdx = dzcpuPkg::flowCb;
			dzcpuPkg::jrNz:     flowIdx = dzcpuPkg::flowJrNz;
			dzcpuPkg::ldCn:     flowIdx = dzcpuPkg::flowLdCn;
			dzcpuPkg::ldAn:     flowIdx = dzcpuPkg::flowLdAn;
			dzcpuPkg::ldIoCA:   flowIdx = dzcpuPkg::flowLdIoCA;
			dzcpuPkg::incC:     flowIdx = dzcpuPkg::flowIncC;
			dzcpuPkg::ldHlA:    flowIdx = dzcpuPkg::flowLdHlA;
			// One-byte ops share flow 0
			dzcpuPkg::xorA:     flowIdx = dzcpuPkg::flowOneByte;
			dzcpuPkg::mopNop:   flowIdx = dzcpuPkg::flowOneByte;
			// Anything else runs as NOP
			default:            flowIdx = dzcpuPkg::flowOneByte;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/dzcpuUcodeRom.sv */
`timescale 1ns/1ps
`default_nettype none

module dzcpuUcodeRom
(
	input  wire dzcpuPkg::flowIdxT  uAddr,
	output dzcpuPkg::uopT           uop
);

	always_comb
	begin
		case (uAddr)
		// Shared one-byte op, XOR A or NOP
		dzcpuPkg::flowOneByte:
			uop = '{dzcpuPkg::eof, dzcpuPkg::oneByte, dzcpuPkg::a};

		// LD SP,nn, two reads in flight back to back
		dzcpuPkg::flowLdSpNn:         uop = '{dzcpuPkg::inc, dzcpuPkg::sma, dzcpuPkg::pc};
		dzcpuPkg::flowLdSpNn + 8'd1:  uop = '{dzcpuPkg::inc, dzcpuPkg::sma, dzcpuPkg::pc};
		dzcpuPkg::flowLdSpNn + 8'd2:  uop = '{dzcpuPkg::op, dzcpuPkg::srm, dzcpuPkg::spl};
		dzcpuPkg::flowLdSpNn + 8'd3:  uop = '{dzcpuPkg::eof, dzcpuPkg::srm, dzcpuPkg::sph};

		// LD HL,nn
		dzcpuPkg::flowLdHlNn:         uop = '{dzcpuPkg::inc, dzcpuPkg::sma, dzcpuPkg::pc};
		dzcpuPkg::flowLdHlNn + 8'd1:  uop = '{dzcpuPkg::inc, dzcpuPkg::sma, dzcpuPkg::pc};
		dzcpuPkg::flowLdHlNn + 8'd2:  uop = '{dzcpuPkg::op, dzcpuPkg::srm, dzcpuPkg::l};
		dzcpuPkg::flowLdHlNn + 8'd3:  uop = '{dzcpuPkg::eof, dzcpuPkg::srm, dzcpuPkg::h};

		// LD (HL-),A
		dzcpuPkg::flowLdHlDecA:        uop = '{dzcpuPkg::op, dzcpuPkg::sma, dzcpuPkg::hl};
		dzcpuPkg::flowLdHlDecA + 8'd1: uop = '{dzcpuPkg::op, dzcpuPkg::smw, dzcpuPkg::a};
		// Write strobe is out this cycle, HL steps after it
		dzcpuPkg::flowLdHlDecA + 8'd2: uop = '{dzcpuPkg::eof, dzcpuPkg::dec16, dzcpuPkg::hl};

		// CB prefix, read the second byte and redecode
		dzcpuPkg::flowCb:         uop = '{dzcpuPkg::op, dzcpuPkg::sma, dzcpuPkg::pc};
		dzcpuPkg::flowCb + 8'd1:  uop = '{dzcpuPkg::op, dzcpuPkg::nop, dzcpuPkg::nullSel};
		dzcpuPkg::flowCb + 8'd2:  uop = '{dzcpuPkg::op, dzcpuPkg::jcb, dzcpuPkg::nullSel};

		// BIT 7,H
		dzcpuPkg::flowBit7H:      uop = '{dzcpuPkg::eof, dzcpuPkg::bitOp, dzcpuPkg::h};

		// JR NZ,n
		dzcpuPkg::flowJrNz:         uop = '{dzcpuPkg::op, dzcpuPkg::sma, dzcpuPkg::pc};
		dzcpuPkg::flowJrNz + 8'd1:  uop = '{dzcpuPkg::op, dzcpuPkg::nop, dzcpuPkg::nullSel};
		// Z set falls through past the offset, else keep x8
		dzcpuPkg::flowJrNz + 8'd2:  uop = '{dzcpuPkg::incEofZ, dzcpuPkg::srm, dzcpuPkg::x8};
		dzcpuPkg::flowJrNz + 8'd3:  uop = '{dzcpuPkg::inc, dzcpuPkg::nop, dzcpuPkg::nullSel};
		// x16 = pc
		dzcpuPkg::flowJrNz + 8'd4:  uop = '{dzcpuPkg::op, dzcpuPkg::sx16r, dzcpuPkg::pc};
		// x16 += sign extended x8
		dzcpuPkg::flowJrNz + 8'd5:  uop = '{dzcpuPkg::op, dzcpuPkg::addx16, dzcpuPkg::x8};
		dzcpuPkg::flowJrNz + 8'd6:  uop = '{dzcpuPkg::eof, dzcpuPkg::spc, dzcpuPkg::x16};

		// LD C,n
		dzcpuPkg::flowLdCn:         uop = '{dzcpuPkg::op, dzcpuPkg::sma, dzcpuPkg::pc};
		dzcpuPkg::flowLdCn + 8'd1:  uop = '{dzcpuPkg::inc, dzcpuPkg::nop, dzcpuPkg::nullSel};
		dzcpuPkg::flowLdCn + 8'd2:  uop = '{dzcpuPkg::eof, dzcpuPkg::srm, dzcpuPkg::c};

		// LD A,n
		dzcpuPkg::flowLdAn:         uop = '{dzcpuPkg::op, dzcpuPkg::sma, dzcpuPkg::pc};
		dzcpuPkg::flowLdAn + 8'd1:  uop = '{dzcpuPkg::inc, dzcpuPkg::nop, dzcpuPkg::nullSel};
		dzcpuPkg::flowLdAn + 8'd2:  uop = '{dzcpuPkg::eof, dzcpuPkg::srm, dzcpuPkg::a};

		// LD (FF00+C),A
		dzcpuPkg::flowLdIoCA:        uop = '{dzcpuPkg::op, dzcpuPkg::sma, dzcpuPkg::ioC};
		dzcpuPkg::flowLdIoCA + 8'd1: uop = '{dzcpuPkg::op, dzcpuPkg::smw, dzcpuPkg::a};
		dzcpuPkg::flowLdIoCA + 8'd2: uop = '{dzcpuPkg::eof, dzcpuPkg::nop, dzcpuPkg::nullSel};

		// INC C
		dzcpuPkg::flowIncC:       uop = '{dzcpuPkg::eof, dzcpuPkg::inc16, dzcpuPkg::c};

		// LD (HL),A
		dzcpuPkg::flowLdHlA:        uop = '{dzcpuPkg::op, dzcpuPkg::sma, dzcpuPkg::hl};
		dzcpuPkg::flowLdHlA + 8'd1: uop = '{dzcpuPkg::op, dzcpuPkg::smw, dzcpuPkg::a};
		dzcpuPkg::flowLdHlA + 8'd2: uop = '{dzcpuPkg::eof, dzcpuPkg::nop, dzcpuPkg::nullSel};

		default:
			uop = '{dzcpuPkg::op, dzcpuPkg::nop, dzcpuPkg::nullSel};
		endcase
	end

endmodule

`default_nettype wire

/* source/dzcpuSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module dzcpuSequencer
(
	input  wire                        clock,
	input  wire                        rst,
	input  wire dzcpuPkg::uopT         uop,
	input  wire dzcpuPkg::flowIdxT     flowIdx,
	input  wire                        zFlag,
	input  wire [7:0]                  opWord,
	output dzcpuPkg::flowIdxT          uAddr,
	output dzcpuPkg::mopT              mop,
	output logic                       cbPage,
	output logic                       exec,
	output dzcpuPkg::fetchStateT       fetchState
);

	// Micro program counter
	dzcpuPkg::flowIdxT uPc;
	// First uop of a flow comes straight from the lookup table
	logic flowStart;

	assign mop = dzcpuPkg::mopT'(opWord);
	assign uAddr = flowStart ? flowIdx : uPc;
	assign exec = (fetchState == dzcpuPkg::execute);

	//////////////////////////////////////////////////////////////////////
	// Fetch FSM and uop stepping
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			fetchState <= dzcpuPkg::fetchAddr;
			uPc <= '0;
			flowStart <= 1'b0;
			cbPage <= 1'b0;
		end
		else
		begin
			case (fetchState)
			dzcpuPkg::fetchAddr:
				fetchState <= dzcpuPkg::fetchWait;
			dzcpuPkg::fetchWait:
				fetchState <= dzcpuPkg::decode;
			// Opcode latched here, flow start used next cycle
			dzcpuPkg::decode:
			begin
				fetchState <= dzcpuPkg::execute;
				flowStart <= 1'b1;
			end
			default:
			begin
				flowStart <= 1'b0;
				cbPage <= 1'b0;
				if (uop.act == dzcpuPkg::jcb)
				begin
					// Second decode pass on the CB page
					fetchState <= dzcpuPkg::decode;
					cbPage <= 1'b1;
				end
				else
				begin
					case (uop.next)
					dzcpuPkg::eof, dzcpuPkg::incEof:
						fetchState <= dzcpuPkg::fetchAddr;
					dzcpuPkg::incEofZ:
						if (zFlag)
							fetchState <= dzcpuPkg::fetchAddr;
						else
							uPc <= uAddr + 8'd1;
					dzcpuPkg::op, dzcpuPkg::inc:
						uPc <= uAddr + 8'd1;
					// Bad sequencing code, back to fetch
					default:
						fetchState <= dzcpuPkg::fetchAddr;
					endcase
				end
			end
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/dzcpuDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module dzcpuDatapath
(
	input  wire                    clock,
	input  wire                    rst,
	input  wire dzcpuPkg::uopT     uop,
	input  wire                    exec,
	input  wire dzcpuPkg::fetchStateT fetchState,
	input  wire [7:0]              memRdData,
	output logic [15:0]            memAddr,
	output logic [7:0]             memWrData,
	output logic                   memWe,
	output logic                   opFetch,
	output logic                   zFlag,
	output logic [7:0]             opWord
);

	// Register file and scratch
	logic [7:0]  regA, regC, regH, regL, x8;
	logic [15:0] sp, pc, x16;

	// Operand reads
	logic [7:0]  rd8;
	logic [15:0] rd16;
	logic        isPair;
	logic [15:0] stepIn, stepOut;

	// Writeback and flag control
	logic        wr8, wr16, zWr, zNext, pcStep;
	logic [7:0]  wrData8;

	always_comb
	begin
		case (uop.sel)
		dzcpuPkg::a:   rd8 = regA;
		dzcpuPkg::c:   rd8 = regC;
		dzcpuPkg::h:   rd8 = regH;
		dzcpuPkg::l:   rd8 = regL;
		dzcpuPkg::spl: rd8 = sp[7:0];
		dzcpuPkg::sph: rd8 = sp[15:8];
		dzcpuPkg::x8:  rd8 = x8;
		default:       rd8 = 8'h00;
		endcase
		case (uop.sel)
		dzcpuPkg::pc:  rd16 = pc;
		dzcpuPkg::hl:  rd16 = {regH, regL};
		// High page I/O
		dzcpuPkg::ioC: rd16 = {8'hFF, regC};
		dzcpuPkg::x16: rd16 = x16;
		default:       rd16 = 16'h0000;
		endcase
	end

	// Increment and decrement share one adder, pairs use all 16 bits
	assign isPair = uop.sel inside {dzcpuPkg::pc, dzcpuPkg::hl, dzcpuPkg::x16};
	assign stepIn = isPair ? rd16 : {8'h00, rd8};
	assign stepOut = (uop.act == dzcpuPkg::inc16) ? stepIn + 16'd1 : stepIn - 16'd1;

	always_comb
	begin
		wr8 = 1'b0;
		wr16 = 1'b0;
		zWr = 1'b0;
		wrData8 = memRdData;
		if (exec)
		begin
			case (uop.act)
			dzcpuPkg::srm:
				wr8 = 1'b1;
			dzcpuPkg::inc16, dzcpuPkg::dec16:
				if (isPair)
					wr16 = 1'b1;
				else
				begin
					// 8-bit step updates Z, pairs leave flags alone
					wr8 = 1'b1;
					wrData8 = stepOut[7:0];
					zWr = 1'b1;
				end
			dzcpuPkg::oneByte:
				if (opWord == dzcpuPkg::xorA)
				begin
					wr8 = 1'b1;
					wrData8 = regA ^ rd8;
					zWr = 1'b1;
				end
			dzcpuPkg::bitOp:
				zWr = 1'b1;
			default:
				wr8 = 1'b0;
			endcase
		end
	end

	// BIT copies the inverted bit, else Z means zero result
	assign zNext = (uop.act == dzcpuPkg::bitOp) ? ~rd8[7] : (wrData8 == 8'h00);
	assign pcStep = exec && (uop.next == dzcpuPkg::inc || uop.next == dzcpuPkg::incEof
		|| (uop.next == dzcpuPkg::incEofZ && zFlag));

	//////////////////////////////////////////////////////////////////////
	// Control state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			pc <= 16'h0000;
			zFlag <= 1'b0;
			memWe <= 1'b0;
			opFetch <= 1'b0;
		end
		else
		begin
			memWe <= exec && (uop.act == dzcpuPkg::smw);
			// Marks the cycle memAddr holds an opcode address
			opFetch <= (fetchState == dzcpuPkg::fetchAddr);
			if (fetchState == dzcpuPkg::decode)
				pc <= pc + 16'd1;
			else if (exec && uop.act == dzcpuPkg::spc)
				pc <= rd16;
			else if (wr16 && uop.sel == dzcpuPkg::pc)
				pc <= stepOut;
			else if (pcStep)
				pc <= pc + 16'd1;
			if (zWr)
				zFlag <= zNext;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registers and memory port payload
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (fetchState == dzcpuPkg::fetchAddr)
			memAddr <= pc;
		else if (exec && uop.act == dzcpuPkg::sma)
			memAddr <= rd16;
		if (exec && uop.act == dzcpuPkg::smw)
			memWrData <= rd8;
		// Opcode, or the CB operand on the second pass
		if (fetchState == dzcpuPkg::decode)
			opWord <= memRdData;
		if (exec && uop.act == dzcpuPkg::sx16r)
			x16 <= rd16;
		if (exec && uop.act == dzcpuPkg::addx16)
			x16 <= x16 + {{8{rd8[7]}}, rd8};
		if (wr16 && uop.sel == dzcpuPkg::x16)
			x16 <= stepOut;
		if (wr16 && uop.sel == dzcpuPkg::hl)
			{regH, regL} <= stepOut;
		if (wr8)
		begin
			case (uop.sel)
			dzcpuPkg::a:   regA <= wrData8;
			dzcpuPkg::c:   regC <= wrData8;
			dzcpuPkg::h:   regH <= wrData8;
			dzcpuPkg::l:   regL <= wrData8;
			dzcpuPkg::spl: sp[7:0] <= wrData8;
			dzcpuPkg::sph: sp[15:8] <= wrData8;
			dzcpuPkg::x8:  x8 <= wrData8;
			default:       regA <= regA;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/dzcpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module dzcpuTop
(
	input  wire         clock,
	input  wire         rst,
	input  wire [7:0]   memRdData,
	output wire [15:0]  memAddr,
	output wire [7:0]   memWrData,
	output wire         memWe,
	output wire         opFetch
);

	// Sequencer to ROM and lookup table
	wire dzcpuPkg::flowIdxT    uAddr;
	wire dzcpuPkg::flowIdxT    flowIdx;
	wire dzcpuPkg::mopT        mop;
	wire                       cbPage;
	wire dzcpuPkg::uopT        uop;

	// Sequencer and datapath handshake
	wire                       exec;
	wire dzcpuPkg::fetchStateT fetchState;
	wire                       zFlag;
	wire [7:0]                 opWord;

	dzcpuSequencer seq
	(
		.clock(clock), .rst(rst), .uop(uop), .flowIdx(flowIdx),
		.zFlag(zFlag), .opWord(opWord), .uAddr(uAddr), .mop(mop),
		.cbPage(cbPage), .exec(exec), .fetchState(fetchState)
	);

	dzcpuFlowLut lut (.mop(mop), .cbPage(cbPage), .flowIdx(flowIdx));

	dzcpuUcodeRom rom (.uAddr(uAddr), .uop(uop));

	dzcpuDatapath dp
	(
		.clock(clock), .rst(rst), .uop(uop), .exec(exec),
		.fetchState(fetchState), .memRdData(memRdData), .memAddr(memAddr),
		.memWrData(memWrData), .memWe(memWe), .opFetch(opFetch),
		.zFlag(zFlag), .opWord(opWord)
	);

endmodule

`default_nettype wire

/* test/dzcpuTbModel.svh */
`ifndef DZCPU_TB_MODEL_SVH
`define DZCPU_TB_MODEL_SVH

// Instruction level model, one instruction per step
// Fills expFetches with one more pc than steps, the last being the next fetch
function automatic void runModel(input int fetchCount);
	logic [7:0]  regA, regC, regH, regL, opcode, operand;
	logic [15:0] regSp, regPc, nextPc;
	logic        zf;
	int          n;
	regA = 8'h00;
	regC = 8'h00;
	regH = 8'h00;
	regL = 8'h00;
	regSp = 16'h0000;
	regPc = 16'h0000;
	zf = 1'b0;
	expFetches.delete();
	expWrites.delete();
	for (n = 0; n < fetchCount; n++)
	begin
		expFetches.push_back(regPc);
		opcode = mem[regPc];
		nextPc = regPc + 16'd1;
		operand = mem[nextPc];
		case (opcode)
		// LD SP,nn and LD HL,nn, low byte first
		8'h31:
		begin
			regSp = {mem[regPc + 16'd2], operand};
			regPc = regPc + 16'd3;
		end
		8'h21:
		begin
			regL = operand;
			regH = mem[regPc + 16'd2];
			regPc = regPc + 16'd3;
		end
		// LD A,n and LD C,n
		8'h3E:
		begin
			regA = operand;
			regPc = regPc + 16'd2;
		end
		8'h0E:
		begin
			regC = operand;
			regPc = regPc + 16'd2;
		end
		// LD (HL),A
		8'h77:
		begin
			expWrites.push_back({regH, regL, regA});
			regPc = nextPc;
		end
		// LD (HL-),A, write then step HL down
		8'h32:
		begin
			expWrites.push_back({regH, regL, regA});
			{regH, regL} = {regH, regL} - 16'd1;
			regPc = nextPc;
		end
		// LD (FF00+C),A
		8'hE2:
		begin
			expWrites.push_back({8'hFF, regC, regA});
			regPc = nextPc;
		end
		8'h0C:
		begin
			regC = regC + 8'd1;
			zf = (regC == 8'h00);
			regPc = nextPc;
		end
		8'hAF:
		begin
			regA = 8'h00;
			zf = 1'b1;
			regPc = nextPc;
		end
		// Only BIT 7,H on the CB page, other codes do nothing
		8'hCB:
		begin
			if (operand == 8'h7C)
				zf = ~regH[7];
			regPc = regPc + 16'd2;
		end
		// JR NZ, offset counts from the byte after the instruction
		8'h20:
		begin
			regPc = regPc + 16'd2;
			if (!zf)
				regPc = regPc + {{8{operand[7]}}, operand};
		end
		default:
			regPc = nextPc;
		endcase
	end
	expFetches.push_back(regPc);
endfunction

`endif

/* test/dzcpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module dzcpuTb;

	// Fetch budgets per test
	localparam int fetchLoads = 5;
	localparam int fetchPostDec = 5;
	localparam int fetchIo = 3;
	localparam int fetchBranch = 8;
	localparam int fetchCb = 6;
	localparam int fetchNop = 8;
	localparam int numTests = 6;
	localparam int totalFetches = fetchLoads + fetchPostDec + fetchIo + fetchBranch
		+ fetchCb + fetchNop;
	// Taken JR NZ is the slowest at fetch plus seven uops
	localparam int longestInstr = 3 + 7;
	localparam int resetCycles = 16;
	localparam int watchdogCycles = 2 * ((totalFetches + numTests) * longestInstr
		+ numTests * (resetCycles + 4));

	// Memory write as seen on the bus
	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0]  data;
	} wrRecT;

	logic        clock = 1'b0;
	logic        rst;
	logic [7:0]  memRdData;
	logic [15:0] memAddr;
	logic [7:0]  memWrData;
	logic        memWe;
	logic        opFetch;

	logic [7:0]  mem [0:65535];
	logic [15:0] progPtr;
	integer      seed;

	// Expected and observed traces
	logic [15:0] expFetches[$];
	logic [15:0] actFetches[$];
	wrRecT       expWrites[$];
	wrRecT       actWrites[$];

	// Test state shared with the compare process
	string       curName;
	logic        checkReq = 1'b0;
	logic        checkAck = 1'b0;
	int          testErrors = 0;
	int          errorCount = 0;
	int          checkCount = 0;
	int          testsFailed = 0;

	`include "dzcpuTbModel.svh"

	dzcpuTop uut
	(
		.clock(clock), .rst(rst), .memRdData(memRdData), .memAddr(memAddr),
		.memWrData(memWrData), .memWe(memWe), .opFetch(opFetch)
	);

	always #10 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Memory model and bus monitor
	//////////////////////////////////////////////////////////////////////

	// One cycle read latency and a log of writes and fetches
	always @(posedge clock)
	begin
		memRdData <= mem[memAddr];
		if (!rst)
		begin
			if (memWe === 1'b1)
				actWrites.push_back({memAddr, memWrData});
			if (opFetch === 1'b1)
				actFetches.push_back(memAddr);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic checkFetch(input string testName, input int idx,
		input logic [15:0] expPc, input logic [15:0] actPc);
		checkCount++;
		if (expPc !== actPc)
		begin
			$display("FAIL %s fetch %0d: expected pc %h, actual pc %h",
				testName, idx, expPc, actPc);
			testErrors++;
		end
	endtask

	task automatic checkWrite(input string testName, input int idx,
		input wrRecT expRec, input wrRecT actRec);
		checkCount++;
		if (expRec !== actRec)
		begin
			$display("FAIL %s write %0d: expected %h <= %h, actual %h <= %h",
				testName, idx, expRec.addr, expRec.data, actRec.addr, actRec.data);
			testErrors++;
		end
	endtask

	// Compare process for one test on each request
	always
	begin
		wait (checkReq === 1'b1);
		testErrors = 0;
		for (int i = 0; i < expFetches.size(); i++)
			checkFetch(curName, i, expFetches[i], actFetches[i]);
		for (int i = 0; i < expWrites.size(); i++)
		begin
			if (i < actWrites.size())
				checkWrite(curName, i, expWrites[i], actWrites[i]);
			else
			begin
				$display("%s: expected write %0d to %h never happened",
					curName, i, expWrites[i].addr);
				testErrors++;
			end
		end
		if (actWrites.size() > expWrites.size())
		begin
			$display("%s: %0d unexpected memory writes", curName,
				actWrites.size() - expWrites.size());
			testErrors++;
		end
		if (testErrors == 0)
			$display("%s: passed, %0d fetches, %0d writes", curName,
				expFetches.size(), expWrites.size());
		else
		begin
			$display("%s: %0d errors", curName, testErrors);
			testsFailed++;
		end
		errorCount = errorCount + testErrors;
		checkAck = 1'b1;
		wait (checkReq === 1'b0);
		checkAck = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Program building and test sequencing
	//////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] randByte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Nonzero so a taken and a skipped JR reach different addresses
	function automatic logic [7:0] branchOffset();
		logic [7:0] b;
		b = randByte();
		while (b == 8'h00)
			b = randByte();
		return b;
	endfunction

	function automatic logic isSupported(input logic [7:0] b);
		case (b)
		8'h00, 8'h0C, 8'h0E, 8'h20, 8'h21, 8'h31, 8'h32, 8'h3E, 8'h77, 8'hAF, 8'hCB, 8'hE2:
			return 1'b1;
		default:
			return 1'b0;
		endcase
	endfunction

	task automatic putByte(input logic [7:0] b);
		mem[progPtr] = b;
		progPtr = progPtr + 16'd1;
	endtask

	// Hold reset while memory is refilled and traces cleared
	task automatic startTest();
		int i;
		@(posedge clock);
		rst <= 1'b1;
		repeat (resetCycles - 1) @(posedge clock);
		for (i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0];
		actFetches.delete();
		actWrites.delete();
		progPtr = 16'h0000;
	endtask

	// Release the CPU and run until the fetch after the last instruction
	task automatic finishTest(input string testName, input int fetchCount);
		curName = testName;
		runModel(fetchCount);
		@(posedge clock);
		rst <= 1'b0;
		while (actFetches.size() <= fetchCount)
			@(negedge clock);
		checkReq = 1'b1;
		wait (checkAck === 1'b1);
		checkReq = 1'b0;
		wait (checkAck === 1'b0);
	endtask

	task automatic testLoads();
		startTest();
		putByte(8'h31);
		putByte(randByte());
		putByte(randByte());
		putByte(8'h21);
		putByte(randByte());
		putByte(randByte());
		putByte(8'h3E);
		putByte(randByte());
		putByte(8'h0E);
		putByte(randByte());
		putByte(8'h77);
		finishTest("loads", fetchLoads);
	endtask

	task automatic testPostDec();
		startTest();
		putByte(8'h21);
		putByte(randByte());
		putByte(randByte());
		putByte(8'h3E);
		putByte(randByte());
		repeat (3) putByte(8'h32);
		finishTest("postDecrement", fetchPostDec);
	endtask

	task automatic testIo();
		startTest();
		putByte(8'h3E);
		putByte(randByte());
		putByte(8'h0E);
		putByte(randByte());
		putByte(8'hE2);
		finishTest("ioWrite", fetchIo);
	endtask

	// XOR A sets Z, INC C to FF clears it before the wrap to 00 sets it again
	// Last INC C to 01 clears Z and the final JR is taken
	task automatic testBranch();
		startTest();
		putByte(8'hAF);
		putByte(8'h20);
		putByte(branchOffset());
		putByte(8'h0E);
		putByte(8'hFE);
		putByte(8'h0C);
		putByte(8'h0C);
		putByte(8'h20);
		putByte(branchOffset());
		putByte(8'h0C);
		putByte(8'h20);
		putByte(branchOffset());
		finishTest("branch", fetchBranch);
	endtask

	// JR falls through with H below 80h and is taken with H at or above 80h
	task automatic testCb();
		startTest();
		putByte(8'h21);
		putByte(randByte());
		putByte(randByte() & 8'h7F);
		putByte(8'hCB);
		putByte(8'h7C);
		putByte(8'h20);
		putByte(branchOffset());
		putByte(8'h21);
		putByte(randByte());
		putByte(randByte() | 8'h80);
		putByte(8'hCB);
		putByte(8'h7C);
		putByte(8'h20);
		putByte(branchOffset());
		finishTest("cbBit7H", fetchCb);
	endtask

	task automatic testUnsupported();
		logic [7:0] b;
		startTest();
		repeat (fetchNop)
		begin
			b = randByte();
			while (isSupported(b))
				b = randByte();
			putByte(b);
		end
		finishTest("unsupported", fetchNop);
	endtask

	initial
	begin
		rst = 1'b1;
		memRdData = 8'h00;
		seed = 32'hb30f_0f8f;
		testLoads();
		testPostDec();
		testIo();
		testBranch();
		testCb();
		testUnsupported();
		$display("%0d tests, %0d failing, %0d checks, %0d errors",
			numTests, testsFailed, checkCount, errorCount);
		if (errorCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(watchdogCycles * 20);
		$display("Timeout, the CPU stopped fetching instructions");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+test
source/dzcpuPkg.sv
source/dzcpuFlowLut.sv
source/dzcpuUcodeRom.sv
source/dzcpuSequencer.sv
source/dzcpuDatapath.sv
source/dzcpuTop.sv
test/dzcpuTb.sv
